/* logic/strm_pkg.sv */
package strm_pkg;

  // ==========================================================
  // Address and data widths
  // ==========================================================

  typedef logic [31:0]  addr_t;      // Byte address from the client
  typedef logic [127:0] beat_t;      // One 128-bit data beat
  typedef logic [18:0]  tag_t;       // Address bits 31 to 13
  typedef logic [2:0]   line_idx_t;  // Address bits 12 to 10 select one of 8 lines
  typedef logic [5:0]   beat_idx_t;  // Address bits 9 to 4 select one of 64 beats

  // ==========================================================
  // Fill sequencer states
  // ==========================================================

  typedef enum logic [2:0] {
    IDLE,    // Waiting for a request or an invalidate
    LOOKUP,  // Cache answers the registered read
    FILL,    // One backing store read per cycle
    SETTLE,  // Last fill write lands in the cache
    RETRY    // Lookup issued again after the fill
  } fill_state_t;

  // ==========================================================
  // Bundles between the sequencer and the cache
  // ==========================================================

  // One beat written into the cache data array
  typedef struct packed {
    logic  wr;   // Write strobe
    addr_t adr;  // Line and beat of the write and the invalidate target
    beat_t dat;  // Beat taken from the backing store
  } fill_beat_t;

  // One lookup of the cache
  typedef struct packed {
    logic  rd;   // Read strobe
    addr_t adr;  // Full byte address with the tag
  } rd_req_t;

endpackage

/* logic/beat_counter.sv */
`timescale 1ns/1ps

module beat_counter (
  input  logic                rst,
  input  logic                wclk,
  input  logic                clr,
  input  logic                en,
  output strm_pkg::beat_idx_t beat,
  output logic                last
);
  import strm_pkg::*;

  localparam beat_idx_t LAST_BEAT = '1;  // Beat 63 closes a line

  // ==========================================================
  // Beat index of the fill in progress
  // ==========================================================

  always_ff @(posedge wclk) begin
    if (rst)
      beat <= '0;
    else if (clr)
      beat <= '0;              // Clear wins over count
    else if (en)
      beat <= beat + 1'b1;
  end

  assign last = (beat == LAST_BEAT);

  // Counting past beat 63 would wrap into the start of the same line
  a_no_wrap: assert property (@(posedge wclk) disable iff (rst)
    en |-> !last)
    else $error("Beat counter enabled on the last beat");

endmodule

/* logic/line_store.sv */
`timescale 1ns/1ps

module line_store #(
  parameter int STORE_BEATS = 4096
) (
  input  logic            wclk,
  input  logic            ld,
  input  strm_pkg::addr_t ld_adr,
  input  strm_pkg::beat_t ld_dat,
  input  logic            rd,
  input  strm_pkg::addr_t rd_adr,
  output strm_pkg::beat_t rd_dat
);
  import strm_pkg::*;

  localparam int IW = $clog2(STORE_BEATS);  // Beat index width

  beat_t mem [0:STORE_BEATS-1];  // Stands in for external DRAM

  logic [IW-1:0] ld_idx;
  logic [IW-1:0] rd_idx;

  // Dropping the byte offset and the upper bits wraps the address into the store
  assign ld_idx = ld_adr[IW+3:4];
  assign rd_idx = rd_adr[IW+3:4];

  // ==========================================================
  // Load port and fetch port
  // ==========================================================

  always_ff @(posedge wclk) begin
    if (ld)
      mem[ld_idx] <= ld_dat;
  end

  // Fetch data shows up one cycle after the read strobe
  always_ff @(posedge wclk) begin
    if (rd)
      rd_dat <= mem[rd_idx];
  end

endmodule

/* logic/strm_read_cache.sv */
`timescale 1ns/1ps

module strm_read_cache (
  input  logic                 rst,
  input  logic                 wclk,
  input  strm_pkg::fill_beat_t wr_beat,
  input  logic                 inv,
  input  strm_pkg::rd_req_t    rd_req,
  output strm_pkg::beat_t      rdat,
  output logic                 hit
);
  import strm_pkg::*;

  // Data array holds 8 lines of 64 beats, addressed by {line, beat}
  beat_t      data_mem [0:511];
  tag_t       tags [0:7];     // One tag per line
  logic [7:0] vbit;           // One valid bit per line

  addr_t      radr_r;         // Lookup address, lined up with rdat
  line_idx_t  wr_line;        // Line touched by a fill write or an invalidate
  line_idx_t  rd_line;        // Line of the registered lookup
  beat_idx_t  wr_bidx;        // Beat of the fill write
  logic       fill_last;      // Fill write of beat 63 completes the line

  assign wr_line   = wr_beat.adr[12:10];
  assign wr_bidx   = wr_beat.adr[9:4];
  assign rd_line   = radr_r[12:10];
  assign fill_last = wr_beat.wr && (wr_bidx == '1);

  // ==========================================================
  // Data array
  // ==========================================================

  always_ff @(posedge wclk) begin
    if (wr_beat.wr)
      data_mem[wr_beat.adr[12:4]] <= wr_beat.dat;  // Line and beat form the index
  end

  // Read port with one cycle of latency; address is kept for the tag compare
  always_ff @(posedge wclk) begin
    if (rd_req.rd) begin
      rdat   <= data_mem[rd_req.adr[12:4]];
      radr_r <= rd_req.adr;
    end
  end

  // ==========================================================
  // Tags and valid bits
  // ==========================================================

  // The tag only changes once the whole line is in place
  always_ff @(posedge wclk) begin
    if (fill_last)
      tags[wr_line] <= wr_beat.adr[31:13];
  end

  always_ff @(posedge wclk) begin
    if (rst)
      vbit <= '0;                   // Every line starts empty
    else if (fill_last)
      vbit[wr_line] <= 1'b1;        // Line becomes usable with its last beat
    else if (inv)
      vbit[wr_line] <= 1'b0;        // Invalidate drops the line at the write address
  end

  // Hit uses the registered address so that tag, valid and data agree
  assign hit = vbit[rd_line] && (tags[rd_line] == radr_r[31:13]);

  // A fill and an invalidate share the write address and must not overlap
  a_no_fill_and_inv: assert property (@(posedge wclk) disable iff (rst)
    !(wr_beat.wr && inv))
    else $error("Cache fill write and invalidate in the same cycle");

endmodule

/* logic/strm_fill_fsm.sv */
`timescale 1ns/1ps

module strm_fill_fsm (
  input  logic                 rst,
  input  logic                 wclk,
  input  logic                 req,
  input  strm_pkg::addr_t      req_adr,
  input  logic                 inv,
  input  strm_pkg::addr_t      inv_adr,
  input  strm_pkg::beat_idx_t  beat,
  input  logic                 last,
  input  logic                 cache_hit,
  input  strm_pkg::beat_t      cache_rdat,
  input  strm_pkg::beat_t      store_dat,
  output logic                 cnt_clr,
  output logic                 cnt_en,
  output logic                 store_rd,
  output strm_pkg::addr_t      store_adr,
  output strm_pkg::rd_req_t    cache_rd,
  output strm_pkg::fill_beat_t cache_wr,
  output logic                 cache_inv,
  output logic                 busy,
  output logic                 done,
  output logic                 hit,
  output strm_pkg::beat_t      rdat
);
  import strm_pkg::*;

  fill_state_t state;
  fill_state_t nxt_state;

  addr_t req_adr_r;   // Address of the request being served
  addr_t wr_adr_r;    // Store read address delayed to match store_dat
  logic  wr_pend;     // A store read was issued last cycle
  logic  filled;      // Set once this request needed a line fill
  logic  is_idle;
  logic  start;       // Request accepted this cycle
  logic  answer;      // Lookup hit, the request completes

  assign is_idle = (state == IDLE);
  assign start   = is_idle && req;
  assign answer  = (state == LOOKUP) && cache_hit;

  // ==========================================================
  // Next state
  // ==========================================================

  always_comb begin
    nxt_state = state;
    case (state)
      IDLE:    if (req) nxt_state = LOOKUP;
      LOOKUP:  nxt_state = cache_hit ? IDLE : FILL;  // Miss starts a fill
      FILL:    if (last) nxt_state = SETTLE;         // Beat 63 was the final issue
      SETTLE:  nxt_state = RETRY;
      RETRY:   nxt_state = LOOKUP;                   // Same path as a new request
      default: nxt_state = IDLE;
    endcase
  end

  always_ff @(posedge wclk) begin
    if (rst) begin
      state   <= IDLE;
      wr_pend <= 1'b0;
      filled  <= 1'b0;
      done    <= 1'b0;
    end else begin
      state   <= nxt_state;
      wr_pend <= store_rd;   // Store data arrives one cycle after the read
      done    <= answer;     // Single cycle pulse
      if (start)
        filled <= 1'b0;
      else if ((state == LOOKUP) && !cache_hit)
        filled <= 1'b1;
    end
  end

  // Request address, delayed fill address and the returned beat
  always_ff @(posedge wclk) begin
    if (start)
      req_adr_r <= req_adr;
    wr_adr_r <= store_adr;
    if (answer) begin
      rdat <= cache_rdat;
      hit  <= !filled;       // Only a first try lookup counts as a hit
    end
  end

  // ==========================================================
  // Outputs to the counter, store and cache
  // ==========================================================

  assign busy     = !is_idle;
  assign store_rd = (state == FILL);
  assign cnt_clr  = (state == LOOKUP);   // Counter is at beat 0 when FILL starts
  assign cnt_en   = store_rd && !last;   // Counter parks on 63 at the end of the line

  // Fill is line aligned, the counter supplies the beat
  assign store_adr = {req_adr_r[31:10], beat, 4'h0};

  // New requests look up straight from the port, a retry uses the held address
  assign cache_rd = '{rd: start || (state == RETRY),
                      adr: is_idle ? req_adr : req_adr_r};

  // While idle the write address carries the invalidate target
  assign cache_wr = '{wr: wr_pend,
                      adr: is_idle ? inv_adr : wr_adr_r,
                      dat: store_dat};

  assign cache_inv = is_idle && inv;

  // The client has no back-pressure, so strobes while busy would be lost
  a_no_strobe_busy: assert property (@(posedge wclk) disable iff (rst)
    busy |-> !(req || inv))
    else $error("Request or invalidate while busy");

endmodule

/* logic/strm_reader_top.sv */
`timescale 1ns/1ps

module strm_reader_top #(
  parameter int STORE_BEATS = 4096
) (
  input  logic            rst,
  input  logic            wclk,
  input  logic            req,
  input  strm_pkg::addr_t req_adr,
  input  logic            ld,
  input  strm_pkg::addr_t ld_adr,
  input  strm_pkg::beat_t ld_dat,
  input  logic            inv,
  input  strm_pkg::addr_t inv_adr,
  output strm_pkg::beat_t rdat,
  output logic            hit,
  output logic            done,
  output logic            busy
);
  import strm_pkg::*;

  // ==========================================================
  // Internal connections
  // ==========================================================

  logic       cnt_clr;     // Sequencer to counter
  logic       cnt_en;
  beat_idx_t  beat;        // Counter back to sequencer
  logic       last;
  logic       store_rd;    // Sequencer to backing store
  addr_t      store_adr;
  beat_t      store_dat;   // Backing store to sequencer
  rd_req_t    cache_rd;    // Lookup into the cache
  fill_beat_t cache_wr;    // Fill write or invalidate target
  logic       cache_inv;
  beat_t      cache_rdat;  // Cache answer
  logic       cache_hit;

  strm_fill_fsm u_fsm (
    .rst        (rst),
    .wclk       (wclk),
    .req        (req),
    .req_adr    (req_adr),
    .inv        (inv),
    .inv_adr    (inv_adr),
    .beat       (beat),
    .last       (last),
    .cache_hit  (cache_hit),
    .cache_rdat (cache_rdat),
    .store_dat  (store_dat),
    .cnt_clr    (cnt_clr),
    .cnt_en     (cnt_en),
    .store_rd   (store_rd),
    .store_adr  (store_adr),
    .cache_rd   (cache_rd),
    .cache_wr   (cache_wr),
    .cache_inv  (cache_inv),
    .busy       (busy),
    .done       (done),
    .hit        (hit),
    .rdat       (rdat)
  );

  beat_counter u_cnt (
    .rst  (rst),
    .wclk (wclk),
    .clr  (cnt_clr),
    .en   (cnt_en),
    .beat (beat),
    .last (last)
  );

  // Store depth comes from the top parameter
  line_store #(.STORE_BEATS(STORE_BEATS)) u_store (
    .wclk   (wclk),
    .ld     (ld),
    .ld_adr (ld_adr),
    .ld_dat (ld_dat),
    .rd     (store_rd),
    .rd_adr (store_adr),
    .rd_dat (store_dat)
  );

  strm_read_cache u_cache (
    .rst     (rst),
    .wclk    (wclk),
    .wr_beat (cache_wr),
    .inv     (cache_inv),
    .rd_req  (cache_rd),
    .rdat    (cache_rdat),
    .hit     (cache_hit)
  );

endmodule

/* bench/strm_reader_tb.sv */
`timescale 1ns/1ps

module strm_reader_tb;
  import strm_pkg::*;

  localparam int STORE_BEATS = 4096;
  localparam int RST_CYCLES  = 5;
  localparam int HIT_CYCLES  = 2;   // Request to done with the line present
  localparam int MISS_CYCLES = 69;  // Lookup, 64 fetches, settle, retry and lookup

  logic  wclk;
  logic  rst;
  logic  req;
  addr_t req_adr;
  logic  ld;
  addr_t ld_adr;
  beat_t ld_dat;
  logic  inv;
  addr_t inv_adr;
  beat_t rdat;
  logic  hit;
  logic  done;
  logic  busy;

  // Reference copy of the store and of what the cache should hold
  beat_t      ref_store [0:STORE_BEATS-1];
  beat_t      ref_lines [0:511];
  tag_t       ref_tags [0:7];
  logic [7:0] ref_valid;
  int         watch_cycles = 0;  // Known once the stimulus file is read

  // Parsed stimulus with one entry per command line
  string op_q[$];
  string name_q[$];
  addr_t adr_q[$];
  string dat_q[$];
  string hit_q[$];

  strm_reader_top #(.STORE_BEATS(STORE_BEATS)) uut (.*);

  initial wclk = 1'b0;
  always #4 wclk = ~wclk;  // 8 ns period

  // ==========================================================
  // Failure reporting
  // ==========================================================

  task automatic report_problem(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "Run stopped on the first failure");
  endtask

  task automatic report_mismatch(input string test, input string what,
                                 input string exp, input string act);
    report_problem($sformatf("error: %s %s expected %s actual %s", test, what, exp, act));
  endtask

  // ==========================================================
  // Reference model
  // ==========================================================

  // Beat address wraps at the store depth so upper address bits drop out
  function automatic int store_index(input addr_t adr);
    return int'({4'h0, adr[31:4]}) % STORE_BEATS;
  endfunction

  // Background data in which every bit of the beat index shows up somewhere
  function automatic beat_t fill_pattern(input logic [31:0] idx);
    return {idx ^ 32'hc0de_0000, idx * 32'h9e37_79b1, ~idx, idx + 32'h5a5a_0000};
  endfunction

  // A miss in the direct-mapped lookup copies the whole line from the store copy
  task automatic model_read(input addr_t adr, output beat_t dat, output logic was_hit);
    line_idx_t line;
    int        b;
    line    = adr[12:10];
    was_hit = ref_valid[line] && (ref_tags[line] == adr[31:13]);
    if (!was_hit) begin
      for (b = 0; b < 64; b++)
        ref_lines[{line, b[5:0]}] = ref_store[store_index({adr[31:10], b[5:0], 4'h0})];
      ref_tags[line]  = adr[31:13];
      ref_valid[line] = 1'b1;  // Line usable once all 64 beats are in
    end
    dat = ref_lines[adr[12:4]];
  endtask

  // ==========================================================
  // Client side drivers are all called on a falling edge
  // ==========================================================

  task automatic load_beat(input addr_t adr, input beat_t dat);
    ld     = 1'b1;
    ld_adr = adr;
    ld_dat = dat;
    ref_store[store_index(adr)] = dat;
    @(negedge wclk);
    ld = 1'b0;
  endtask

  task automatic invalidate_line(input addr_t adr);
    assert (!busy) else report_problem("Invalidate issued while the DUT is busy");
    inv     = 1'b1;
    inv_adr = adr;
    ref_valid[adr[12:10]] = 1'b0;  // Only the line index matters, not the tag
    @(negedge wclk);
    inv = 1'b0;
  endtask

  task automatic read_and_check(input string test, input addr_t adr,
                                input string dat_tok, input string hit_tok);
    beat_t exp_dat;
    logic  exp_hit;
    logic  model_hit;
    int    cycles;
    int    exp_cycles;
    assert (!busy) else report_problem($sformatf("%s: read issued while busy", test));
    model_read(adr, exp_dat, model_hit);
    exp_hit = (hit_tok == "1");
    assert (model_hit == exp_hit)
      else report_problem($sformatf("%s: stimulus hit flag disagrees with the model", test));
    if (dat_tok != "model")
      void'($sscanf(dat_tok, "%h", exp_dat));  // Fixed beat given in the file
    exp_cycles = exp_hit ? HIT_CYCLES : MISS_CYCLES;
    req     = 1'b1;
    req_adr = adr;
    @(negedge wclk);
    req    = 1'b0;
    cycles = 1;
    while (!done) begin  // busy has to cover every cycle up to done
      assert (busy) else report_problem($sformatf("%s: busy dropped before done", test));
      @(negedge wclk);
      cycles++;
    end
    assert (!busy) else report_problem($sformatf("%s: busy still high with done", test));
    assert (hit === exp_hit)
      else report_mismatch(test, "hit", $sformatf("%0b", exp_hit), $sformatf("%0b", hit));
    assert (rdat === exp_dat)
      else report_mismatch(test, "rdat", $sformatf("%h", exp_dat), $sformatf("%h", rdat));
    assert (cycles == exp_cycles)
      else report_mismatch(test, "latency", $sformatf("%0d", exp_cycles),
                           $sformatf("%0d", cycles));
    @(negedge wclk);
    assert (!done) else report_problem($sformatf("%s: done lasted more than one cycle", test));
  endtask

  // ==========================================================
  // Main sequence
  // ==========================================================

  initial begin
    int            fd;
    int            k;
    string         op;
    logic [511:0]  tok_w;
    logic [511:0]  name_w;
    logic [511:0]  dat_w;
    logic [511:0]  hit_w;
    logic [1023:0] rest_w;
    addr_t         adr_v;
    beat_t         ld_v;
    rst       = 1'b1;
    req       = 1'b0;
    req_adr   = '0;
    ld        = 1'b0;
    ld_adr    = '0;
    ld_dat    = '0;
    inv       = 1'b0;
    inv_adr   = '0;
    ref_valid = '0;
    void'($urandom(32'h674));
    fd = $fopen("bench/strm_stim.txt", "r");
    if (fd == 0)
      report_problem("Could not open bench/strm_stim.txt");
    while ($fscanf(fd, "%s", tok_w) == 1) begin
      op = string'(tok_w);
      if (op[0] == "#") begin
        void'($fgets(rest_w, fd));  // Rest of a comment line
      end else begin
        if ($fscanf(fd, "%s %h %s %s", name_w, adr_v, dat_w, hit_w) != 4)
          report_problem($sformatf("A %s line in the stimulus file is incomplete", op));
        op_q.push_back(op);
        name_q.push_back(string'(name_w));
        adr_q.push_back(adr_v);
        dat_q.push_back(string'(dat_w));
        hit_q.push_back(string'(hit_w));
      end
    end
    $fclose(fd);
    watch_cycles = STORE_BEATS + RST_CYCLES + 100 * op_q.size();
    repeat (RST_CYCLES) @(posedge wclk);
    @(negedge wclk);
    rst = 1'b0;
    assert (!busy && !done) else report_problem("busy or done is high after reset");
    for (k = 0; k < STORE_BEATS; k++)
      load_beat(addr_t'(k) << 4, fill_pattern(k));  // Whole store gets known data
    for (k = 0; k < op_q.size(); k++) begin
      if (op_q[k] == "load") begin
        if (dat_q[k] == "rand")
          ld_v = {$urandom, $urandom, $urandom, $urandom};
        else
          void'($sscanf(dat_q[k], "%h", ld_v));
        load_beat(adr_q[k], ld_v);
      end else if (op_q[k] == "inv") begin
        invalidate_line(adr_q[k]);
      end else if (op_q[k] == "read") begin
        read_and_check(name_q[k], adr_q[k], dat_q[k], hit_q[k]);
      end else begin
        report_problem($sformatf("Unknown command %s in the stimulus file", op_q[k]));
      end
    end
    $display("Testbench passed");
    $finish;
  end

  // Watchdog sized from the preload and the number of commands
  initial begin
    wait (watch_cycles > 0);
    repeat (watch_cycles) @(posedge wclk);
    report_problem($sformatf("Watchdog expired after %0d cycles", watch_cycles));
  end

endmodule

/* bench/strm_stim.txt */
# op  name  address  data (load: hex or rand, read: expected hex or model)  hit
# Reads wait for done; hit is the expected flag, loads and invalidates use -
load  ld_l2_b5            00000850  0123456789abcdef0011223344556677  -
load  ld_l2_b0            00000800  ffeeddccbbaa99887766554433221100  -
load  ld_l2_b63           00000bf0  rand                              -
read  rd_cold_miss        00000850  0123456789abcdef0011223344556677  0
read  rd_line_b0          00000800  ffeeddccbbaa99887766554433221100  1
read  rd_line_b63         00000bf0  model                             1
read  rd_line_b17         00000910  model                             1
read  rd_byte_offset      0000085c  0123456789abcdef0011223344556677  1
# Same line index, other tag
load  ld_t1_b5            00002850  rand                              -
read  rd_conflict_miss    00002850  model                             0
read  rd_conflict_b63     00002bf0  model                             1
read  rd_first_again      00000850  0123456789abcdef0011223344556677  0
read  rd_first_b63        00000bf0  model                             1
# Stale data until the line is invalidated
load  ld_stale_b5         00000850  a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0  -
load  ld_stale_b63        00000bf0  rand                              -
read  rd_stale_hit        00000850  0123456789abcdef0011223344556677  1
read  rd_stale_b63        00000bf0  model                             1
inv   inv_line2           00000800  -                                 -
read  rd_after_inv        00000850  a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0  0
read  rd_after_inv_b63    00000bf0  model                             1
read  rd_after_inv_b0     00000800  ffeeddccbbaa99887766554433221100  1
inv   inv_other_tag       0001a800  -                                 -
read  rd_inv_by_line      00000850  a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0  0
# Store index wraps, top address shares beat 4095 with 0000fff0
load  ld_l7_top           fffffff0  rand                              -
read  rd_wrap_top         fffffff0  model                             0
read  rd_wrap_low         0000fff0  model                             0
read  rd_wrap_low_b0      0000fc00  model                             1
read  rd_wrap_top_again   fffffff0  model                             0
load  ld_l0_b0            00000000  rand                              -
load  ld_l0_b63           000003f0  rand                              -
read  rd_l0_b63_first     000003f0  model                             0
read  rd_l0_b0            00000000  model                             1
read  rd_l5_miss          00001400  model                             0
read  rd_l5_b62           000017e0  model                             1
inv   inv_empty_line4     00001000  -                                 -
read  rd_l5_kept          00001400  model                             1
read  rd_l2_still         00000bf0  model                             1

/* sim.f */
logic/strm_pkg.sv
logic/beat_counter.sv
logic/line_store.sv
logic/strm_read_cache.sv
logic/strm_fill_fsm.sv
logic/strm_reader_top.sv
bench/strm_reader_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing
TOP       := strm_reader_tb
RTL_TOP   := strm_reader_top
FILELIST  := sim.f
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG) || ! grep -q "Testbench passed" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
